// File: compile.f
verilog/attn_pkg.sv
verilog/attn_cfg_regs.sv
verilog/sa_matmul.sv
verilog/row_softmax.sv
verilog/attn_ctrl.sv
verilog/attn_top.sv
testbench/tb_attn_top.sv

// File: Makefile
TB_TOP = tb_attn_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module $(TB_TOP) -o sim_attn

run: build
	./obj_dir/sim_attn

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module attn_top

clean:
	rm -rf obj_dir

// File: testbench/tb_attn_top.sv
`timescale 1ns/10ps

module tb_attn_top;
    import attn_pkg::*;

    localparam int TIMEOUT_CYCLES = 25 * 200;   // 25 runs of at most 200 cycles
    localparam int PV_SHIFT_REF   = 7;

    logic       I_CLK;
    logic       I_ASYN_RSTN;
    logic       i_start;
    mat_qkv_t   i_mat_q;
    mat_qkv_t   i_mat_k;
    mat_qkv_t   i_mat_v;
    logic       i_cfg_wr;
    logic [1:0] i_cfg_addr;
    logic [7:0] i_cfg_wdata;
    logic [7:0] o_cfg_rdata;
    logic       o_busy;
    logic       o_done;
    logic       o_att_vld;
    mat_qkv_t   o_att_data;

    attn_cfg_t   cfg_model;                     // expected configuration
    mat_qkv_t    exp_att;                       // expected o for the current run
    int          runs;                          // accepted starts
    int          done_count;
    int          cycle_count;
    logic [31:0] lcg_state;

    attn_top attn_top_i (.*);

    initial begin
        I_CLK = 1'b0;
        forever #5 I_CLK = ~I_CLK;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int requant_ref(input int acc, input int sh);
        int t;
        t = acc >>> sh;
        if (t > 127) begin
            return 127;
        end else if (t < -128) begin
            return -128;
        end
        return t;
    endfunction

    function automatic mat_qkv_t attn_ref(input mat_qkv_t q, input mat_qkv_t k,
                                          input mat_qkv_t v, input attn_cfg_t cfg);
        int       s [SEQ_LEN][SEQ_LEN];
        int       p [SEQ_LEN][SEQ_LEN];
        int       e [SEQ_LEN];
        int       acc;
        int       m;
        int       d;
        int       sum;
        mat_qkv_t o;
        for (int r = 0; r < SEQ_LEN; r++) begin
            for (int c = 0; c < SEQ_LEN; c++) begin
                acc = 0;
                for (int j = 0; j < D_K; j++) begin
                    acc += int'(q[r][j]) * int'(k[c][j]);
                end
                s[r][c] = requant_ref(acc, int'(cfg.qk_shift));
                s[r][c] = requant_ref(s[r][c] * int'(s8_t'(cfg.scale_val)),
                                      int'(cfg.scale_shift));
            end
        end
        for (int r = 0; r < SEQ_LEN; r++) begin
            m = s[r][0];
            for (int c = 1; c < SEQ_LEN; c++) begin
                if (s[r][c] > m) m = s[r][c];
            end
            sum = 0;
            for (int c = 0; c < SEQ_LEN; c++) begin
                d    = m - s[r][c];
                e[c] = (d >= 8) ? 0 : (128 >> d);     // shift exponent
                sum += e[c];
            end
            for (int c = 0; c < SEQ_LEN; c++) begin
                p[r][c] = (e[c] * 128) / sum;
                if (p[r][c] > 127) p[r][c] = 127;
            end
        end
        for (int r = 0; r < SEQ_LEN; r++) begin
            for (int c = 0; c < D_K; c++) begin
                acc = 0;
                for (int j = 0; j < SEQ_LEN; j++) begin
                    acc += p[r][j] * int'(v[j][c]);
                end
                o[r][c] = s8_t'(requant_ref(acc, PV_SHIFT_REF));
            end
        end
        return o;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checking and drivers

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic fill_random(output mat_qkv_t m);
        for (int r = 0; r < SEQ_LEN; r++) begin
            for (int c = 0; c < D_K; c++) begin
                lcg_state = lcg_step(lcg_state);
                m[r][c]   = s8_t'(lcg_state[23:16]);  // upper bits are less periodic
            end
        end
    endtask

    task automatic cfg_write(input logic [1:0] a, input logic [7:0] d);
        @(posedge I_CLK);
        i_cfg_wr    <= 1'b1;
        i_cfg_addr  <= a;
        i_cfg_wdata <= d;
        @(posedge I_CLK);
        i_cfg_wr    <= 1'b0;
    endtask

    task automatic read_check(input logic [1:0] a, input logic [7:0] exp, input string name);
        @(posedge I_CLK);
        i_cfg_addr <= a;
        @(posedge I_CLK);
        check_value(name, o_cfg_rdata, exp);
    endtask

    task automatic start_run(input mat_qkv_t q, input mat_qkv_t k, input mat_qkv_t v);
        @(posedge I_CLK);
        i_mat_q <= q;
        i_mat_k <= k;
        i_mat_v <= v;
        i_start <= 1'b1;
        exp_att = attn_ref(q, k, v, cfg_model);
        runs++;
        @(posedge I_CLK);
        i_start <= 1'b0;
    endtask

    task automatic finish_run();
        do @(posedge I_CLK); while (o_done !== 1'b1);
        @(posedge I_CLK);
        check_value("done_count", done_count, runs);  // one pulse per run
        check_value("o_busy", o_busy, 1'b0);
    endtask

    // compare o on every done pulse
    always @(posedge I_CLK) begin
        if (o_done === 1'b1) begin
            done_count++;
            check_value("o_att_data", o_att_data, exp_att);
            check_value("o_att_vld", o_att_vld, 1'b1);
        end
    end

    always @(posedge I_CLK) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("CHECKS FAILED");
            $fatal(1, "timeout: no completion within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus

    initial begin
        mat_qkv_t q;
        mat_qkv_t k;
        mat_qkv_t v;
        I_ASYN_RSTN = 1'b0;
        i_start     = 1'b0;
        i_mat_q     = '0;
        i_mat_k     = '0;
        i_mat_v     = '0;
        i_cfg_wr    = 1'b0;
        i_cfg_addr  = 2'd0;
        i_cfg_wdata = 8'd0;
        runs        = 0;
        done_count  = 0;
        cycle_count = 0;
        lcg_state   = 32'd1362;
        cfg_model   = '{qk_shift: 4'd3, scale_val: 8'd91, scale_shift: 4'd8};
        repeat (10) @(posedge I_CLK);
        I_ASYN_RSTN <= 1'b1;
        @(posedge I_CLK);
        check_value("o_busy", o_busy, 1'b0);
        check_value("o_done", o_done, 1'b0);
        check_value("o_att_vld", o_att_vld, 1'b0);
        read_check(CFG_ADDR_QK_SHIFT, 8'd3, "qk_shift");
        read_check(CFG_ADDR_SCALE_VAL, 8'd91, "scale_val");
        read_check(CFG_ADDR_SCALE_SHIFT, 8'd8, "scale_shift");

        for (int n = 0; n < 10; n++) begin          // default configuration
            fill_random(q);
            fill_random(k);
            fill_random(v);
            start_run(q, k, v);
            finish_run();
        end

        cfg_write(CFG_ADDR_QK_SHIFT, 8'd5);
        cfg_write(CFG_ADDR_SCALE_VAL, 8'd120);
        cfg_write(CFG_ADDR_SCALE_SHIFT, 8'd6);
        cfg_model = '{qk_shift: 4'd5, scale_val: 8'd120, scale_shift: 4'd6};
        read_check(CFG_ADDR_QK_SHIFT, 8'd5, "qk_shift");
        read_check(CFG_ADDR_SCALE_VAL, 8'd120, "scale_val");
        read_check(CFG_ADDR_SCALE_SHIFT, 8'd6, "scale_shift");
        for (int n = 0; n < 2; n++) begin
            fill_random(q);
            fill_random(k);
            fill_random(v);
            start_run(q, k, v);
            finish_run();
        end

        // config write and second start while busy
        fill_random(q);
        fill_random(k);
        fill_random(v);
        start_run(q, k, v);
        repeat (3) @(posedge I_CLK);
        cfg_write(CFG_ADDR_QK_SHIFT, 8'd9);
        read_check(CFG_ADDR_QK_SHIFT, 8'd5, "qk_shift");
        read_check(CFG_ADDR_STATUS, 8'd1, "status");
        @(posedge I_CLK);
        i_start <= 1'b1;
        @(posedge I_CLK);
        i_start <= 1'b0;
        finish_run();
        read_check(CFG_ADDR_STATUS, 8'd0, "status");

        cfg_write(CFG_ADDR_QK_SHIFT, 8'd3);
        cfg_write(CFG_ADDR_SCALE_VAL, 8'd91);
        cfg_write(CFG_ADDR_SCALE_SHIFT, 8'd8);
        cfg_model = '{qk_shift: 4'd3, scale_val: 8'd91, scale_shift: 4'd8};

        ////////////////////////////////////////////////////////////////////
        // extremes
        start_run({32{8'h7f}}, {32{8'h7f}}, {32{8'h7f}});
        finish_run();
        start_run({32{8'h80}}, {32{8'h80}}, {32{8'h7f}});
        finish_run();
        start_run({32{8'h7f}}, {32{8'h80}}, {32{8'h80}});  // negative saturation
        finish_run();
        fill_random(v);
        start_run('0, '0, v);                       // equal scores, p = 32
        finish_run();

        // o_att_vld holds between runs
        repeat (5) @(posedge I_CLK);
        check_value("o_att_vld", o_att_vld, 1'b1);
        fill_random(q);
        fill_random(k);
        start_run(q, k, v);
        @(posedge I_CLK);
        check_value("o_att_vld", o_att_vld, 1'b0);
        finish_run();

        // quiet period, a stray run would finish inside it
        repeat (200) @(posedge I_CLK);
        if (done_count != runs) begin
            $display("CHECKS FAILED");
            $fatal(1, "wrong number of done pulses at end of test");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// File: verilog/attn_top.sv
`timescale 1ns/10ps

module attn_top (
    input  logic               I_CLK,
    input  logic               I_ASYN_RSTN,
    input  logic               i_start,
    input  attn_pkg::mat_qkv_t i_mat_q,
    input  attn_pkg::mat_qkv_t i_mat_k,
    input  attn_pkg::mat_qkv_t i_mat_v,
    input  logic               i_cfg_wr,
    input  logic [1:0]         i_cfg_addr,
    input  logic [7:0]         i_cfg_wdata,
    output logic [7:0]         o_cfg_rdata,
    output logic               o_busy,
    output logic               o_done,
    output logic               o_att_vld,
    output attn_pkg::mat_qkv_t o_att_data
);
    import attn_pkg::*;

    attn_cfg_t  cfg;
    logic       sa_start;
    sa_opa_t    sa_op_a;
    sa_opb_t    sa_op_b;
    logic [3:0] sa_k_dim;
    logic [3:0] sa_shift;
    sa_res_t    sa_result;
    logic       sa_vld;
    logic       sm_start;
    sm_row_t    sm_row;
    sm_row_t    sm_prob;
    logic       sm_vld;

    attn_cfg_regs u_cfg (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .i_cfg_wr    (i_cfg_wr),
        .i_cfg_addr  (i_cfg_addr),
        .i_cfg_wdata (i_cfg_wdata),
        .i_busy      (o_busy),
        .o_cfg       (cfg),
        .o_cfg_rdata (o_cfg_rdata)
    );

    attn_ctrl u_ctrl (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .i_start     (i_start),
        .i_mat_q     (i_mat_q),
        .i_mat_k     (i_mat_k),
        .i_mat_v     (i_mat_v),
        .i_cfg       (cfg),
        .i_sa_result (sa_result),
        .i_sa_vld    (sa_vld),
        .i_sm_prob   (sm_prob),
        .i_sm_vld    (sm_vld),
        .o_sa_start  (sa_start),
        .o_sa_op_a   (sa_op_a),
        .o_sa_op_b   (sa_op_b),
        .o_sa_k_dim  (sa_k_dim),
        .o_sa_shift  (sa_shift),
        .o_sm_start  (sm_start),
        .o_sm_row    (sm_row),
        .o_busy      (o_busy),
        .o_done      (o_done),
        .o_att_vld   (o_att_vld),
        .o_att_data  (o_att_data)
    );

    sa_matmul u_sa (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .i_start     (sa_start),
        .i_op_a      (sa_op_a),
        .i_op_b      (sa_op_b),
        .i_k_dim     (sa_k_dim),
        .i_shift     (sa_shift),
        .o_result    (sa_result),
        .o_vld       (sa_vld)
    );

    row_softmax u_sm (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .i_start     (sm_start),
        .i_row       (sm_row),
        .o_prob      (sm_prob),
        .o_vld       (sm_vld)
    );

endmodule

// File: verilog/attn_ctrl.sv
`timescale 1ns/10ps

module attn_ctrl (
    input  logic                I_CLK,
    input  logic                I_ASYN_RSTN,
    input  logic                i_start,
    input  attn_pkg::mat_qkv_t  i_mat_q,        // held while busy
    input  attn_pkg::mat_qkv_t  i_mat_k,
    input  attn_pkg::mat_qkv_t  i_mat_v,
    input  attn_pkg::attn_cfg_t i_cfg,
    input  attn_pkg::sa_res_t   i_sa_result,
    input  logic                i_sa_vld,
    input  attn_pkg::sm_row_t   i_sm_prob,
    input  logic                i_sm_vld,
    output logic                o_sa_start,
    output attn_pkg::sa_opa_t   o_sa_op_a,
    output attn_pkg::sa_opb_t   o_sa_op_b,
    output logic [3:0]          o_sa_k_dim,
    output logic [3:0]          o_sa_shift,
    output logic                o_sm_start,
    output attn_pkg::sm_row_t   o_sm_row,
    output logic                o_busy,
    output logic                o_done,
    output logic                o_att_vld,
    output attn_pkg::mat_qkv_t  o_att_data
);
    import attn_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_QK,          // s = q * k^T
        ST_SCALE,       // s * diag(scale)
        ST_SM,          // p = softmax(s), row by row
        ST_PV0,         // o[:, 0:3] = p * v
        ST_PV1,         // o[:, 4:7]
        ST_DONE
    } ctrl_state_t;

    ctrl_state_t state;
    logic        pend;                      // launch the current pass next cycle
    logic [1:0]  row_q;
    logic [2:0]  col_base;
    sa_res_t     score_q;
    sa_res_t     prob_q;

    assign col_base = (state == ST_PV1) ? 3'd4 : 3'd0;
    assign o_sm_row = score_q[row_q];

    //////////////////////////////////////////////////////////////////////
    // array operands, selected by pass

    always_comb begin
        o_sa_op_a  = '0;
        o_sa_op_b  = '0;
        o_sa_k_dim = 4'(SA_N);
        o_sa_shift = PV_SHIFT;
        case (state)
            ST_QK: begin
                o_sa_op_a  = i_mat_q;           // same shape as the left operand
                for (int k = 0; k < D_K; k++) begin
                    for (int c = 0; c < SEQ_LEN; c++) begin
                        o_sa_op_b[k][c] = i_mat_k[c][k];
                    end
                end
                o_sa_k_dim = 4'(D_K);
                o_sa_shift = i_cfg.qk_shift;
            end
            ST_SCALE: begin
                for (int r = 0; r < SA_N; r++) begin
                    for (int c = 0; c < SA_N; c++) begin
                        o_sa_op_a[r][c] = score_q[r][c];
                    end
                    o_sa_op_b[r][r] = i_cfg.scale_val;
                end
                o_sa_shift = i_cfg.scale_shift;
            end
            ST_PV0, ST_PV1: begin
                for (int r = 0; r < SA_N; r++) begin
                    for (int c = 0; c < SA_N; c++) begin
                        o_sa_op_a[r][c] = prob_q[r][c];
                        o_sa_op_b[r][c] = i_mat_v[r][col_base + c];
                    end
                end
            end
            default: ;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // pass sequencer

    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            state      <= ST_IDLE;
            pend       <= 1'b0;
            row_q      <= 2'd0;
            o_sa_start <= 1'b0;
            o_sm_start <= 1'b0;
            o_busy     <= 1'b0;
            o_done     <= 1'b0;
            o_att_vld  <= 1'b0;
        end else begin
            o_sa_start <= 1'b0;
            o_sm_start <= 1'b0;
            o_done     <= 1'b0;
            if (pend) begin
                pend <= 1'b0;
                if (state == ST_SM) begin
                    o_sm_start <= 1'b1;
                end else begin
                    o_sa_start <= 1'b1;
                end
            end
            case (state)
                ST_IDLE: begin
                    if (i_start) begin
                        state     <= ST_QK;
                        pend      <= 1'b1;
                        o_busy    <= 1'b1;
                        o_att_vld <= 1'b0;
                    end
                end
                ST_QK: begin
                    if (i_sa_vld) begin
                        state <= ST_SCALE;
                        pend  <= 1'b1;
                    end
                end
                ST_SCALE: begin
                    if (i_sa_vld) begin
                        state <= ST_SM;
                        pend  <= 1'b1;
                        row_q <= 2'd0;
                    end
                end
                ST_SM: begin
                    if (i_sm_vld) begin
                        pend <= 1'b1;
                        if (row_q == 2'(SEQ_LEN - 1)) begin
                            state <= ST_PV0;
                        end else begin
                            row_q <= row_q + 2'd1;
                        end
                    end
                end
                ST_PV0: begin
                    if (i_sa_vld) begin
                        state <= ST_PV1;
                        pend  <= 1'b1;
                    end
                end
                ST_PV1: if (i_sa_vld) state <= ST_DONE;
                default: begin
                    state     <= ST_IDLE;
                    o_busy    <= 1'b0;
                    o_done    <= 1'b1;
                    o_att_vld <= 1'b1;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // result capture

    always_ff @(posedge I_CLK) begin
        if (i_sa_vld) begin
            case (state)
                ST_QK, ST_SCALE: score_q <= i_sa_result;
                ST_PV0, ST_PV1: begin
                    for (int r = 0; r < SA_N; r++) begin
                        for (int c = 0; c < SA_N; c++) begin
                            o_att_data[r][col_base + c] <= i_sa_result[r][c];
                        end
                    end
                end
                default: ;
            endcase
        end
        if (i_sm_vld) begin
            prob_q[row_q] <= i_sm_prob;
        end
    end

    a_done_after_busy: assert property (
        @(posedge I_CLK) disable iff (!I_ASYN_RSTN)
        o_done |-> $past(o_busy)
    ) else $error("done without a running pass");

endmodule

// File: verilog/row_softmax.sv
`timescale 1ns/10ps

module row_softmax (
    input  logic              I_CLK,
    input  logic              I_ASYN_RSTN,
    input  logic              i_start,      // one-cycle pulse
    input  attn_pkg::sm_row_t i_row,        // scaled scores
    output attn_pkg::sm_row_t o_prob,       // q7 probabilities
    output logic              o_vld
);
    import attn_pkg::*;

    typedef enum logic [2:0] {SM_IDLE, SM_MAX, SM_SUM, SM_DIV, SM_OUT} sm_phase_t;

    sm_phase_t   phase;
    logic [1:0]  idx_q;                     // element under division
    logic [2:0]  bit_q;                     // quotient bit step
    sm_row_t     row_q;
    s8_t         max_q;
    logic [7:0]  e_q [SEQ_LEN];
    logic [9:0]  sum_q;                     // 128..512
    logic [10:0] rem_q;
    logic [5:0]  quot_q;

    s8_t         row_max;
    logic [7:0]  e_c [SEQ_LEN];
    logic [9:0]  sum_c;
    logic [10:0] rem_sh;
    logic [10:0] rem_nx;
    logic        q_bit;
    logic        ovf;

    always_comb begin
        row_max = row_q[0];
        for (int i = 1; i < SEQ_LEN; i++) begin
            if (row_q[i] > row_max) begin
                row_max = row_q[i];
            end
        end
    end

    // exponent is 128 >> (max - x), gone after 8 steps
    always_comb begin
        logic [8:0] d;
        sum_c = '0;
        for (int i = 0; i < SEQ_LEN; i++) begin
            d      = 9'(max_q - row_q[i]);
            e_c[i] = (d >= 9'd8) ? 8'd0 : 8'(8'd128 >> d);
            sum_c  = sum_c + 10'(e_c[i]);
        end
    end

    // restoring divider, e*128 / sum
    assign rem_sh = {rem_q[9:0], 1'b0};
    assign q_bit  = (rem_sh >= {1'b0, sum_q});
    assign rem_nx = q_bit ? rem_sh - {1'b0, sum_q} : rem_sh;
    assign ovf    = ({2'd0, e_q[idx_q]} >= sum_q);    // quotient would reach 128

    //////////////////////////////////////////////////////////////////////
    // control

    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            phase <= SM_IDLE;
            idx_q <= 2'd0;
            bit_q <= 3'd0;
            o_vld <= 1'b0;
        end else begin
            o_vld <= 1'b0;
            case (phase)
                SM_IDLE: if (i_start) phase <= SM_MAX;
                SM_MAX:  phase <= SM_SUM;
                SM_SUM: begin
                    phase <= SM_DIV;
                    idx_q <= 2'd0;
                    bit_q <= 3'd0;
                end
                SM_DIV: begin
                    if (bit_q == 3'd6) begin
                        bit_q <= 3'd0;
                        idx_q <= idx_q + 2'd1;
                        if (idx_q == 2'(SEQ_LEN - 1)) begin
                            phase <= SM_OUT;
                        end
                    end else begin
                        bit_q <= bit_q + 3'd1;
                    end
                end
                default: begin
                    o_vld <= 1'b1;
                    phase <= SM_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // datapath

    always_ff @(posedge I_CLK) begin
        case (phase)
            SM_IDLE: if (i_start) row_q <= i_row;
            SM_MAX:  max_q <= row_max;
            SM_SUM: begin
                e_q   <= e_c;
                sum_q <= sum_c;
                rem_q <= 11'(e_c[0]);
            end
            SM_DIV: begin
                quot_q <= {quot_q[4:0], q_bit};
                rem_q  <= rem_nx;
                if (bit_q == 3'd6) begin
                    o_prob[idx_q] <= ovf ? 8'sd127 : s8_t'({1'b0, quot_q, q_bit});
                    rem_q         <= 11'(e_q[2'(idx_q + 2'd1)]);  // next element
                end
            end
            default: ;
        endcase
    end

    a_sum_floor: assert property (
        @(posedge I_CLK) disable iff (!I_ASYN_RSTN)
        (phase == SM_DIV) |-> (sum_q >= 10'(P_ONE))
    ) else $error("exponent sum below one");

endmodule

// File: verilog/sa_matmul.sv
`timescale 1ns/10ps

module sa_matmul (
    input  logic              I_CLK,
    input  logic              I_ASYN_RSTN,
    input  logic              i_start,      // one-cycle pulse
    input  attn_pkg::sa_opa_t i_op_a,       // held until o_vld
    input  attn_pkg::sa_opb_t i_op_b,
    input  logic [3:0]        i_k_dim,      // inner dimension, 1..MAX_K
    input  logic [3:0]        i_shift,      // requant shift
    output attn_pkg::sa_res_t o_result,
    output logic              o_vld
);
    import attn_pkg::*;

    typedef enum logic [1:0] {MM_IDLE, MM_LOAD, MM_ACC, MM_SAT} mm_phase_t;

    mm_phase_t               phase;
    logic [3:0]              k_q;
    logic [3:0]              shift_q;
    logic [2:0]              idx_q;         // inner index
    logic signed [ACC_W-1:0] acc [SA_N][SA_N];

    // arithmetic shift then clamp to int8
    function automatic s8_t requant(input logic signed [ACC_W-1:0] v,
                                    input logic [3:0] sh);
        logic signed [ACC_W-1:0] t;
        t = v >>> sh;
        if (t > 127) begin
            return 8'sd127;
        end else if (t < -128) begin
            return -8'sd128;
        end
        return s8_t'(t[7:0]);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // sequencing

    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            phase   <= MM_IDLE;
            k_q     <= 4'd0;
            shift_q <= 4'd0;
            idx_q   <= 3'd0;
            o_vld   <= 1'b0;
        end else begin
            o_vld <= 1'b0;
            case (phase)
                MM_IDLE: begin
                    if (i_start) begin
                        phase   <= MM_LOAD;
                        k_q     <= i_k_dim;
                        shift_q <= i_shift;
                    end
                end
                MM_LOAD: begin
                    phase <= MM_ACC;
                    idx_q <= 3'd0;
                end
                MM_ACC: begin
                    idx_q <= idx_q + 3'd1;
                    if ({1'b0, idx_q} == k_q - 4'd1) begin
                        phase <= MM_SAT;
                    end
                end
                default: begin                      // saturate and report
                    o_vld <= 1'b1;
                    phase <= MM_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // mac array

    always_ff @(posedge I_CLK) begin
        for (int r = 0; r < SA_N; r++) begin
            for (int c = 0; c < SA_N; c++) begin
                case (phase)
                    MM_LOAD: acc[r][c] <= '0;
                    MM_ACC:  acc[r][c] <= acc[r][c] + i_op_a[r][idx_q] * i_op_b[idx_q][c];
                    MM_SAT:  o_result[r][c] <= requant(acc[r][c], shift_q);
                    default: ;
                endcase
            end
        end
    end

    a_kdim_range: assert property (
        @(posedge I_CLK) disable iff (!I_ASYN_RSTN)
        i_start |-> (i_k_dim >= 4'd1 && i_k_dim <= 4'(MAX_K))
    ) else $error("inner dimension out of range");

    a_start_idle: assert property (
        @(posedge I_CLK) disable iff (!I_ASYN_RSTN)
        i_start |-> (phase == MM_IDLE)
    ) else $error("start while a pass is running");

endmodule

// File: verilog/attn_cfg_regs.sv
`timescale 1ns/10ps

module attn_cfg_regs (
    input  logic                I_CLK,
    input  logic                I_ASYN_RSTN,
    input  logic                i_cfg_wr,
    input  logic [1:0]          i_cfg_addr,
    input  logic [7:0]          i_cfg_wdata,
    input  logic                i_busy,         // from the sequencer
    output attn_pkg::attn_cfg_t o_cfg,
    output logic [7:0]          o_cfg_rdata
);
    import attn_pkg::*;

    // writes only land while the engine is idle
    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            o_cfg <= CFG_RST;
        end else if (i_cfg_wr && !i_busy) begin
            case (i_cfg_addr)
                CFG_ADDR_QK_SHIFT:    o_cfg.qk_shift    <= i_cfg_wdata[3:0];
                CFG_ADDR_SCALE_VAL:   o_cfg.scale_val   <= i_cfg_wdata;
                CFG_ADDR_SCALE_SHIFT: o_cfg.scale_shift <= i_cfg_wdata[3:0];
                default: ;                              // status is read only
            endcase
        end
    end

    always_comb begin
        case (i_cfg_addr)
            CFG_ADDR_QK_SHIFT:    o_cfg_rdata = {4'd0, o_cfg.qk_shift};
            CFG_ADDR_SCALE_VAL:   o_cfg_rdata = o_cfg.scale_val;
            CFG_ADDR_SCALE_SHIFT: o_cfg_rdata = {4'd0, o_cfg.scale_shift};
            default:              o_cfg_rdata = {7'd0, i_busy};
        endcase
    end

    a_no_write_busy: assert property (
        @(posedge I_CLK) disable iff (!I_ASYN_RSTN)
        (i_cfg_wr && i_busy) |=> $stable(o_cfg)
    ) else $error("configuration changed while busy");

endmodule

// File: verilog/attn_pkg.sv
package attn_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes

    localparam int SEQ_LEN = 4;                 // rows of q, k, v
    localparam int D_K     = 8;                 // head dimension
    localparam int SA_N    = 4;                 // array edge
    localparam int MAX_K   = 8;                 // deepest inner dimension
    localparam int ACC_W   = 24;                // accumulator width
    localparam int P_ONE   = 128;               // softmax numerator scale

    localparam logic [3:0] PV_SHIFT = 4'd7;     // p is q7, so drop 7 bits

    localparam logic [1:0] CFG_ADDR_QK_SHIFT    = 2'd0;
    localparam logic [1:0] CFG_ADDR_SCALE_VAL   = 2'd1;
    localparam logic [1:0] CFG_ADDR_SCALE_SHIFT = 2'd2;
    localparam logic [1:0] CFG_ADDR_STATUS      = 2'd3;

    //////////////////////////////////////////////////////////////////////
    // data types

    typedef logic signed [7:0] s8_t;

    typedef s8_t [SEQ_LEN-1:0][D_K-1:0]   mat_qkv_t;   // [row][col]
    typedef s8_t [SA_N-1:0][MAX_K-1:0]    sa_opa_t;    // left operand
    typedef s8_t [MAX_K-1:0][SA_N-1:0]    sa_opb_t;    // right operand
    typedef s8_t [SA_N-1:0][SA_N-1:0]     sa_res_t;
    typedef s8_t [SEQ_LEN-1:0]            sm_row_t;

    typedef struct packed {
        logic [3:0] qk_shift;
        logic [7:0] scale_val;      // unsigned; the array sees it as int8
        logic [3:0] scale_shift;
    } attn_cfg_t;

    localparam attn_cfg_t CFG_RST = '{
        qk_shift:    4'd3,
        scale_val:   8'd91,         // about 128/sqrt(2)
        scale_shift: 4'd8
    };

endpackage
